//--- rtl/obj_pkg.sv
package obj_pkg;

    // screen geometry.
    localparam int num_cols = 240;
    localparam int col_w = 8;

    // object table.
    localparam int num_objs = 16;
    localparam int obj_idx_w = 4;

    // pattern memory holds square tiles addressed as {tile, pixel row, pixel column}.
    localparam int num_tiles = 16;
    localparam int tile_w = 4;
    localparam int tile_px = 8;
    localparam int pat_addr_w = 10;

    // attribute word layout.
    localparam int attr_w = 32;
    localparam int attr_y_lsb = 0;
    localparam int attr_x_lsb = 8;
    localparam int attr_tile_lsb = 16;
    localparam int attr_pal_bit = 20;
    localparam int attr_en_bit = 21;

    // scanner state encodings.
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_clear = 3'd1;
    localparam logic [2:0] st_test = 3'd2;
    localparam logic [2:0] st_fetch = 3'd3;
    localparam logic [2:0] st_write = 3'd4;
    localparam logic [2:0] st_done = 3'd5;

    // one pixel word, read either as a direct colour or as a palette index.
    typedef union packed {
        struct packed {
            logic       prio;
            logic [4:0] red;
            logic [4:0] green;
            logic [4:0] blue;
        } direct;
        struct packed {
            logic       prio;
            logic [6:0] unused;
            logic [7:0] index;
        } palette;
    } obj_pixel_t;

endpackage

//--- rtl/obj_attr_table.sv
module obj_attr_table (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            attr_we,
    input  logic [obj_pkg::obj_idx_w-1:0]   attr_addr,
    input  logic [obj_pkg::attr_w-1:0]      attr_wdata,
    input  logic [obj_pkg::obj_idx_w-1:0]   attr_raddr,
    output logic [obj_pkg::attr_w-1:0]      attr_rdata
);

    logic [obj_pkg::attr_w-1:0] attr_regs [obj_pkg::num_objs];

    // a cleared word has the enable bit low, so every object starts hidden.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < obj_pkg::num_objs; i++) begin
                attr_regs[i] <= '0;
            end
        end else if (attr_we) begin
            attr_regs[attr_addr] <= attr_wdata;
        end
    end

    assign attr_rdata = attr_regs[attr_raddr]; // the scanner tests this in the same cycle.

endmodule

//--- rtl/obj_pattern_mem.sv
module obj_pattern_mem (
    input  logic                            clock,
    input  logic                            pat_we,
    input  logic [obj_pkg::pat_addr_w-1:0]  pat_addr,
    input  obj_pkg::obj_pixel_t             pat_wdata,
    input  logic [obj_pkg::pat_addr_w-1:0]  pat_raddr,
    output obj_pkg::obj_pixel_t             pat_rdata
);

    obj_pkg::obj_pixel_t mem [obj_pkg::num_tiles * obj_pkg::tile_px * obj_pkg::tile_px];

    always_ff @(posedge clock) begin
        if (pat_we) begin
            mem[pat_addr] <= pat_wdata;
        end
    end

    // registered read, so data follows the address by one cycle.
    always_ff @(posedge clock) begin
        pat_rdata <= mem[pat_raddr];
    end

endmodule

//--- rtl/obj_line_scanner.sv
module obj_line_scanner (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            row_valid,
    input  logic [obj_pkg::col_w-1:0]       row,
    output logic                            row_ready,
    output logic                            row_done,
    output logic [obj_pkg::obj_idx_w-1:0]   attr_raddr,
    input  logic [obj_pkg::attr_w-1:0]      attr_rdata,
    output logic [obj_pkg::pat_addr_w-1:0]  pat_raddr,
    input  obj_pkg::obj_pixel_t             pat_rdata,
    output logic [obj_pkg::col_w-1:0]       wr_row,
    output logic                            clear,
    output logic                            we,
    output logic                            palettemode,
    output logic [obj_pkg::col_w-1:0]       wcol,
    output obj_pkg::obj_pixel_t             wdata
);

    logic [2:0]                             state;
    logic [obj_pkg::col_w-1:0]              row_q;
    logic [obj_pkg::obj_idx_w-1:0]          obj_q;
    logic [$clog2(obj_pkg::tile_px)-1:0]    cnt;
    logic                                   pal_q;
    logic                                   cap_en;
    logic [$clog2(obj_pkg::tile_px)-1:0]    cap_idx;
    logic [obj_pkg::col_w-1:0]              x_q;
    logic [obj_pkg::tile_w-1:0]             tile_q;
    logic [$clog2(obj_pkg::tile_px)-1:0]    py_q;
    obj_pkg::obj_pixel_t                    line_q [obj_pkg::tile_px];
    logic [obj_pkg::col_w-1:0]              obj_y;
    logic [obj_pkg::col_w:0]                dy;
    logic [obj_pkg::col_w:0]                col_sum;
    logic                                   hit;
    logic                                   last_obj;

    assign obj_y = attr_rdata[obj_pkg::attr_y_lsb +: obj_pkg::col_w];
    // a row above the object wraps to a large value and fails the range test.
    assign dy = {1'b0, row_q} - {1'b0, obj_y};
    assign hit = attr_rdata[obj_pkg::attr_en_bit]
                 && (dy < (obj_pkg::col_w + 1)'(obj_pkg::tile_px));
    assign last_obj = (obj_q == obj_pkg::obj_idx_w'(obj_pkg::num_objs - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= obj_pkg::st_idle;
            row_q <= '0;
            obj_q <= '0;
            cnt <= '0;
            pal_q <= 1'b0;
        end else begin
            case (state)
                obj_pkg::st_idle: begin
                    if (row_valid) begin
                        row_q <= row;
                        state <= obj_pkg::st_clear;
                    end
                end
                obj_pkg::st_clear: begin
                    obj_q <= '0;
                    state <= obj_pkg::st_test;
                end
                obj_pkg::st_test: begin
                    cnt <= '0;
                    if (hit) begin
                        pal_q <= attr_rdata[obj_pkg::attr_pal_bit];
                        state <= obj_pkg::st_fetch;
                    end else if (last_obj) begin
                        state <= obj_pkg::st_done;
                    end else begin
                        obj_q <= obj_q + 1'b1;
                    end
                end
                obj_pkg::st_fetch: begin
                    cnt <= cnt + 1'b1; // wraps to zero for the first write.
                    if (&cnt) state <= obj_pkg::st_write;
                end
                obj_pkg::st_write: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt) begin
                        if (last_obj) begin
                            state <= obj_pkg::st_done;
                        end else begin
                            obj_q <= obj_q + 1'b1;
                            state <= obj_pkg::st_test;
                        end
                    end
                end
                default: state <= obj_pkg::st_idle;
            endcase
        end
    end

    // pattern data lags its address by one cycle, so the capture slot is delayed too.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cap_en <= 1'b0;
            cap_idx <= '0;
        end else begin
            cap_en <= (state == obj_pkg::st_fetch);
            cap_idx <= cnt;
        end
    end

    always_ff @(posedge clock) begin
        if (state == obj_pkg::st_test && hit) begin
            x_q <= attr_rdata[obj_pkg::attr_x_lsb +: obj_pkg::col_w];
            tile_q <= attr_rdata[obj_pkg::attr_tile_lsb +: obj_pkg::tile_w];
            py_q <= dy[$clog2(obj_pkg::tile_px)-1:0];
        end
        if (cap_en) line_q[cap_idx] <= pat_rdata;
    end

    assign col_sum = {1'b0, x_q} + (obj_pkg::col_w + 1)'(cnt);

    assign row_ready = (state == obj_pkg::st_idle);
    assign row_done = (state == obj_pkg::st_done);
    assign attr_raddr = obj_q;
    assign pat_raddr = {tile_q, py_q, cnt};
    assign wr_row = row_q;
    assign clear = (state == obj_pkg::st_clear);
    // columns past the right edge are simply not written.
    assign we = (state == obj_pkg::st_write) && (col_sum < (obj_pkg::col_w + 1)'(obj_pkg::num_cols));
    assign wcol = col_sum[obj_pkg::col_w-1:0];
    assign wdata = line_q[cnt];
    assign palettemode = pal_q;

endmodule

//--- rtl/obj_row_buffer.sv
module obj_row_buffer (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        clear,
    input  logic                        we,
    input  logic                        palettemode,
    input  logic [obj_pkg::col_w-1:0]   wcol,
    input  obj_pkg::obj_pixel_t         wdata,
    input  logic [obj_pkg::col_w-1:0]   rcol,
    output obj_pkg::obj_pixel_t         rdata
);

    obj_pkg::obj_pixel_t            pix_q [obj_pkg::num_cols];
    logic [obj_pkg::num_cols-1:0]   col_sel;
    logic [obj_pkg::num_cols-1:0]   col_open;
    logic                           wr_opaque;

    // transparency is judged in the view that the current object uses.
    function automatic logic is_transparent(input obj_pkg::obj_pixel_t pix, input logic pal);
        if (pal) begin
            return (pix.palette.index == '0);
        end
        return ({pix.direct.red, pix.direct.green, pix.direct.blue} == '0);
    endfunction

    always_comb begin
        col_sel = '0;
        if (wcol < obj_pkg::col_w'(obj_pkg::num_cols)) begin
            col_sel[wcol] = 1'b1;
        end
    end

    assign wr_opaque = !is_transparent(wdata, palettemode);

    for (genvar i = 0; i < obj_pkg::num_cols; i++) begin : g_col
        assign col_open[i] = is_transparent(pix_q[i], palettemode);

        // an opaque column is kept, so the first object drawn wins.
        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                pix_q[i] <= '0;
            end else if (en && clear) begin
                pix_q[i] <= '0;
            end else if (en && we && col_sel[i] && col_open[i] && wr_opaque) begin
                pix_q[i] <= wdata;
            end
        end
    end

    always_comb begin
        rdata = '0; // off-screen columns read as zero.
        if (rcol < obj_pkg::col_w'(obj_pkg::num_cols)) begin
            rdata = pix_q[rcol];
        end
    end

endmodule

//--- rtl/obj_row_double_buffer.sv
module obj_row_double_buffer (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [obj_pkg::col_w-1:0]   wr_row,
    input  logic                        clear,
    input  logic                        we,
    input  logic                        palettemode,
    input  logic [obj_pkg::col_w-1:0]   wcol,
    input  obj_pkg::obj_pixel_t         wdata,
    input  logic [obj_pkg::col_w-1:0]   rcol,
    output obj_pkg::obj_pixel_t         rdata
);

    logic                   sel_odd;
    obj_pkg::obj_pixel_t    rdata_even;
    obj_pkg::obj_pixel_t    rdata_odd;

    assign sel_odd = wr_row[0]; // row parity picks the half being drawn.

    obj_row_buffer even (
        .clock, .rst_n, .en(!sel_odd), .clear, .we, .palettemode,
        .wcol, .wdata, .rcol, .rdata(rdata_even)
    );

    obj_row_buffer odd (
        .clock, .rst_n, .en(sel_odd), .clear, .we, .palettemode,
        .wcol, .wdata, .rcol, .rdata(rdata_odd)
    );

    // the display always sees the half that is not being drawn.
    always_ff @(posedge clock) begin
        rdata <= sel_odd ? rdata_even : rdata_odd;
    end

endmodule

//--- rtl/obj_line_top.sv
module obj_line_top (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            attr_we,
    input  logic [obj_pkg::obj_idx_w-1:0]   attr_addr,
    input  logic [obj_pkg::attr_w-1:0]      attr_wdata,
    input  logic                            pat_we,
    input  logic [obj_pkg::pat_addr_w-1:0]  pat_addr,
    input  obj_pkg::obj_pixel_t             pat_wdata,
    input  logic                            row_valid,
    input  logic [obj_pkg::col_w-1:0]       row,
    output logic                            row_ready,
    output logic                            row_done,
    input  logic [obj_pkg::col_w-1:0]       rcol,
    output obj_pkg::obj_pixel_t             rdata
);

    logic [obj_pkg::obj_idx_w-1:0]  attr_raddr;
    logic [obj_pkg::attr_w-1:0]     attr_rdata;
    logic [obj_pkg::pat_addr_w-1:0] pat_raddr;
    obj_pkg::obj_pixel_t            pat_rdata;
    logic [obj_pkg::col_w-1:0]      wr_row;
    logic                           clear;
    logic                           we;
    logic                           palettemode;
    logic [obj_pkg::col_w-1:0]      wcol;
    obj_pkg::obj_pixel_t            wdata;

    obj_attr_table u_attr_table (
        .clock, .rst_n,
        .attr_we, .attr_addr, .attr_wdata,
        .attr_raddr, .attr_rdata
    );

    obj_pattern_mem u_pattern_mem (
        .clock,
        .pat_we, .pat_addr, .pat_wdata,
        .pat_raddr, .pat_rdata
    );

    obj_line_scanner u_scanner (
        .clock, .rst_n,
        .row_valid, .row, .row_ready, .row_done,
        .attr_raddr, .attr_rdata,
        .pat_raddr, .pat_rdata,
        .wr_row, .clear, .we, .palettemode, .wcol, .wdata
    );

    obj_row_double_buffer u_row_buffer (
        .clock, .rst_n,
        .wr_row, .clear, .we, .palettemode, .wcol, .wdata,
        .rcol, .rdata
    );

endmodule

//--- dv/obj_line_tb.sv
module obj_line_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 1000;

    logic                            clock;
    logic                            rst_n;
    logic                            attr_we;
    logic [obj_pkg::obj_idx_w-1:0]   attr_addr;
    logic [obj_pkg::attr_w-1:0]      attr_wdata;
    logic                            pat_we;
    logic [obj_pkg::pat_addr_w-1:0]  pat_addr;
    obj_pkg::obj_pixel_t             pat_wdata;
    logic                            row_valid;
    logic [obj_pkg::col_w-1:0]       row;
    logic                            row_ready;
    logic                            row_done;
    logic [obj_pkg::col_w-1:0]       rcol;
    obj_pkg::obj_pixel_t             rdata;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int cur_test;
    int test_err0;
    int accept_count;
    int done_count = 0;
    bit stalled;

    obj_line_top dut (
        .clock, .rst_n,
        .attr_we, .attr_addr, .attr_wdata,
        .pat_we, .pat_addr, .pat_wdata,
        .row_valid, .row, .row_ready, .row_done,
        .rcol, .rdata
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // every pulse of row_done is counted, wanted or not.
    always @(negedge clock) begin
        if (rst_n && row_done) done_count = done_count + 1;
    end

    function automatic string test_name(input int t);
        case (t)
            1: return "single object";
            2: return "overlap priority";
            3: return "palette transparency";
            4: return "clipping";
            5: return "clear per row";
            6: return "back-pressure";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_pixel(input obj_pkg::obj_pixel_t got, input obj_pkg::obj_pixel_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is 0x%h, expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is 0x%h, expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error: %s is 0x%0h, expected 0x%0h", what, got, exp);
        end
    endtask

    task automatic write_attr(input logic [obj_pkg::obj_idx_w-1:0] addr,
                              input logic [obj_pkg::attr_w-1:0] data);
        @(posedge clock);
        #1;
        attr_we = 1'b1;
        attr_addr = addr;
        attr_wdata = data;
        @(posedge clock);
        #1;
        attr_we = 1'b0;
    endtask

    task automatic write_pattern(input logic [obj_pkg::pat_addr_w-1:0] addr,
                                 input obj_pkg::obj_pixel_t data);
        @(posedge clock);
        #1;
        pat_we = 1'b1;
        pat_addr = addr;
        pat_wdata = data;
        @(posedge clock);
        #1;
        pat_we = 1'b0;
    endtask

    // each word of the tile is its base plus its full pattern address.
    task automatic fill_tile(input logic [obj_pkg::tile_w-1:0] tile, input logic [15:0] base);
        logic [obj_pkg::pat_addr_w-1:0] addr;
        for (int i = 0; i < obj_pkg::tile_px * obj_pkg::tile_px; i++) begin
            addr = {tile, i[5:0]};
            write_pattern(addr, base + {6'b0, addr});
        end
    endtask

    // leaves row_valid high; the caller decides when to drop it.
    task automatic send_row(input logic [obj_pkg::col_w-1:0] r, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        @(posedge clock);
        #1;
        row = r;
        row_valid = 1'b1;
        while (!ok && n < timeout_cycles) begin
            @(negedge clock);
            ok = row_ready; // the next rising edge takes the row.
            n++;
        end
        @(posedge clock);
        #1;
        if (ok) begin
            accept_count++;
        end else begin
            errors++;
            stalled = 1'b1;
            $display("row 0x%h was never accepted", r);
        end
    endtask

    task automatic wait_done(input logic [obj_pkg::col_w-1:0] r);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clock);
            seen = row_done;
            n++;
        end
        if (!seen) begin
            errors++;
            stalled = 1'b1;
            $display("row 0x%h never finished drawing", r);
        end
    endtask

    task automatic draw_and_show(input logic [obj_pkg::col_w-1:0] r);
        bit ok;
        send_row(r, ok);
        row_valid = 1'b0;
        if (ok) wait_done(r);
        // a row of the other parity swaps the halves, so the drawn one becomes readable.
        if (!stalled) begin
            send_row(r ^ 8'h01, ok);
            row_valid = 1'b0;
            if (ok) wait_done(r ^ 8'h01);
        end
    endtask

    task automatic burst_rows(input logic [obj_pkg::col_w-1:0] ra);
        logic [obj_pkg::col_w-1:0] rb;
        bit ok;
        bit seen;
        int n;
        rb = ra ^ 8'h01;
        seen = 1'b0;
        n = 0;
        send_row(ra, ok);
        if (ok) begin
            row = rb; // row_valid stays high for the second row.
            while (!seen && n < timeout_cycles) begin
                @(negedge clock);
                seen = row_done;
                if (!seen) check_bit(row_ready, 1'b0, "row_ready while drawing");
                n++;
            end
            if (seen) begin
                @(negedge clock);
                check_bit(row_ready, 1'b1, "row_ready after row_done");
                @(posedge clock);
                #1;
                accept_count++;
                row_valid = 1'b0;
                wait_done(rb);
            end else begin
                errors++;
                stalled = 1'b1;
                $display("row 0x%h never finished drawing while the next row waited", ra);
            end
        end
        row_valid = 1'b0;
    endtask

    task automatic read_pixel(input logic [obj_pkg::col_w-1:0] col,
                              output obj_pkg::obj_pixel_t val);
        @(posedge clock);
        #1;
        rcol = col;
        @(posedge clock); // rdata is registered one cycle after rcol.
        @(negedge clock);
        val = rdata;
    endtask

    task automatic finish_test();
        if (cur_test != 0) begin
            @(posedge clock);
            check_count(done_count, accept_count, "row_done count");
            tests_run++;
            if (errors == test_err0) begin
                $display("test %0d, %s: pass", cur_test, test_name(cur_test));
            end else begin
                tests_failed++;
                $display("test %0d, %s: fail with %0d errors", cur_test,
                         test_name(cur_test), errors - test_err0);
            end
            cur_test = 0;
        end
    endtask

    task automatic start_test(input int t);
        if (t != cur_test) begin
            finish_test();
            cur_test = t;
            test_err0 = errors;
        end
    endtask

    task automatic run_command(input logic [7:0] ch, input logic [31:0] a, input logic [31:0] b);
        obj_pkg::obj_pixel_t got;
        case (ch)
            "W": write_attr(a[obj_pkg::obj_idx_w-1:0], b);
            "P": write_pattern(a[obj_pkg::pat_addr_w-1:0], b[15:0]);
            "T": fill_tile(a[obj_pkg::tile_w-1:0], b[15:0]);
            "R": begin
                start_test(int'(a));
                draw_and_show(b[obj_pkg::col_w-1:0]);
            end
            "B": begin
                start_test(int'(a));
                burst_rows(b[obj_pkg::col_w-1:0]);
            end
            "E": begin
                read_pixel(a[obj_pkg::col_w-1:0], got);
                check_pixel(got, b[15:0], $sformatf("rdata at column 0x%h", a[7:0]));
            end
            default: begin
                errors++;
                stalled = 1'b1;
                $display("unknown command %c in the stimulus file", ch);
            end
        endcase
    endtask

    initial begin
        int fd;
        int c;
        int n;
        logic [7:0] ch;
        logic [31:0] a;
        logic [31:0] b;
        rst_n = 1'b0;
        attr_we = 1'b0;
        attr_addr = '0;
        attr_wdata = '0;
        pat_we = 1'b0;
        pat_addr = '0;
        pat_wdata = '0;
        row_valid = 1'b0;
        row = '0;
        rcol = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = 0;
        test_err0 = 0;
        accept_count = 0;
        stalled = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;

        fd = $fopen("dv/obj_line_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/obj_line_stimulus.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1 && !stalled) begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c != -1 && c[7:0] != 8'h0a) begin
                        c = $fgetc(fd);
                    end
                end else if (ch != 8'h20 && ch != 8'h0a && ch != 8'h0d && ch != 8'h09) begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        errors++;
                        stalled = 1'b1;
                        $display("a stimulus line for command %c is malformed", ch);
                    end else begin
                        run_command(ch, a, b);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- dv/obj_line_stimulus.txt
# W obj word: attribute write | P addr word: pattern write | T tile base: tile word = base + address
# R test row: draw row, then show it | B test row: row and row^1 back to back | E col word: expect
T 1 4000
T 2 1000
T 3 2000
T 4 0001
T 5 3000
P 085 0000
P 086 0000
P 102 7f00
W 0 00211008
W 1 00223028
W 2 00233428
W 3 00346040
W 4 00246048
W 5 0025ec80
R 1 0a
E 0f 0000
E 10 4050
E 13 4053
E 17 4057
E 18 0000
R 1 0f
E 10 4078
E 17 407f
R 1 07
E 10 0000
R 1 10
E 10 0000
R 2 28
E 30 1080
E 34 1084
E 35 20c1
E 36 20c2
E 37 1087
E 38 20c4
E 3b 20c7
E 3c 0000
R 2 29
E 35 108d
E 36 108e
R 3 40
E 60 0101
E 61 0102
E 62 0000
E 63 0104
R 3 48
E 60 0101
E 62 7f00
E 67 0108
R 4 82
E eb 0000
E ec 3150
E ef 3153
E f0 0000
E fa 0000
R 5 0a
E 10 4050
R 5 64
E 10 0000
E 13 0000
E 17 0000
B 6 2a
E 30 1090
E 37 1097
E 38 20d4
E 3b 20d7

//--- list.f
rtl/obj_pkg.sv
rtl/obj_attr_table.sv
rtl/obj_pattern_mem.sv
rtl/obj_line_scanner.sv
rtl/obj_row_buffer.sv
rtl/obj_row_double_buffer.sv
rtl/obj_line_top.sv
dv/obj_line_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with verilator, runs it, and checks the log for the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps --top-module obj_line_tb \
    -f list.f -o obj_line_sim
./obj_dir/obj_line_sim | tee sim.log
grep -q "^Simulation passed$" sim.log
